// ==== all.f ====
logic/commit_trace_pkg.sv
logic/trace_port_stage.sv
logic/pc_queue.sv
logic/pc_merge_arbiter.sv
logic/perf_counters.sv
logic/commit_trace_unit.sv
verification/tb_commit_trace_unit.sv

// ==== logic/commit_trace_pkg.sv ====
// Shared sizes, counter addresses and entry types for the commit trace unit.
// Every RTL file refers to these through commit_trace_pkg::name.

package commit_trace_pkg;

  // ------------------------------
  // sizes
  // ------------------------------
  localparam int unsigned NR_COMMIT_PORTS = 2;
  localparam int unsigned VLEN            = 40;
  localparam int unsigned INSN_W          = 32;
  localparam int unsigned XLEN            = 64;

  // per-port PC queue, depth is a power of two so pointers wrap by themselves
  localparam int unsigned PC_QUEUE_DEPTH  = 16;
  localparam int unsigned PC_QUEUE_PTR_W  = 4;

  // ------------------------------
  // performance counter map
  // ------------------------------
  localparam int unsigned PERF_ADDR_W = 5;

  localparam logic [PERF_ADDR_W-1:0] PERF_CYCLE       = 5'd0;
  localparam logic [PERF_ADDR_W-1:0] PERF_INSTRET     = 5'd1;
  localparam logic [PERF_ADDR_W-1:0] PERF_EXCEPTION   = 5'd2;
  localparam logic [PERF_ADDR_W-1:0] PERF_INTERRUPT   = 5'd3;
  localparam logic [PERF_ADDR_W-1:0] PERF_ICACHE_MISS = 5'd4;
  localparam logic [PERF_ADDR_W-1:0] PERF_DCACHE_MISS = 5'd5;
  localparam logic [PERF_ADDR_W-1:0] PERF_IF_EMPTY    = 5'd6;

  // addresses at or above this read as zero
  localparam int unsigned NR_PERF_CNT = 7;

  // ------------------------------
  // cause word
  // ------------------------------
  // top bit set means asynchronous trap (interrupt)
  typedef struct packed {
    logic            is_interrupt;
    logic [XLEN-2:0] code;
  } cause_fields_t;

  typedef union packed {
    logic [XLEN-1:0] word;
    cause_fields_t   fields;
  } cause_t;

  // ------------------------------
  // entries
  // ------------------------------
  // one retiring slot as seen on a commit port
  typedef struct packed {
    logic [VLEN-1:0]   pc;
    logic [INSN_W-1:0] insn;
    logic              ex_valid;
    cause_t            cause;
  } commit_entry_t;

  // registered trace port entry, one per commit port
  typedef struct packed {
    logic              valid;
    logic              exception;
    logic              interrupt;
    logic [VLEN-1:0]   iaddr;
    logic [INSN_W-1:0] insn;
    cause_t            cause;
  } trace_entry_t;

  // CSR-style counter access, sampled every cycle
  typedef struct packed {
    logic [PERF_ADDR_W-1:0] addr;
    logic                   we;
    logic [XLEN-1:0]        wdata;
  } perf_req_t;

endpackage

// ==== logic/commit_trace_unit.sv ====
// Commit-side observation block: registered trace port, merged stream of
// retired PCs and the performance counters, all fed from the commit ports.
`timescale 1ns/1ps

module commit_trace_unit (
  input  logic                                         clk_i,
  input  logic                                         arst_n_i,
  input  commit_trace_pkg::commit_entry_t [commit_trace_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  logic                                         debug_mode_i,
  input  logic                                         icache_miss_i,
  input  logic                                         dcache_miss_i,
  input  logic                                         if_empty_i,
  input  commit_trace_pkg::perf_req_t                  perf_req_i,
  output commit_trace_pkg::trace_entry_t  [commit_trace_pkg::NR_COMMIT_PORTS-1:0] trace_o,
  output logic [commit_trace_pkg::XLEN-1:0]            perf_rdata_o,
  output logic                                         pc_valid_o,
  output logic [commit_trace_pkg::VLEN-1:0]            pc_o,
  output logic                                         pc_overflow_o
);

  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0]                             pc_push;
  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0]                             pc_pop;
  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0]                             pc_empty;
  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0]                             pc_overflow;
  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0][commit_trace_pkg::VLEN-1:0] pc_head;

  // ------------------------------
  // trace port
  // ------------------------------
  trace_port_stage trace_port_stage_inst (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .commit_instr_i ( commit_instr_i ),
    .commit_ack_i   ( commit_ack_i   ),
    .trace_o        ( trace_o        )
  );

  // ------------------------------
  // retired PC queues
  // ------------------------------
  for (genvar i = 0; i < commit_trace_pkg::NR_COMMIT_PORTS; i++) begin : gen_pc_queue
    // only cleanly retired instructions enter the PC stream
    assign pc_push[i] = commit_ack_i[i] & ~commit_instr_i[i].ex_valid;

    pc_queue pc_queue_inst (
      .clk_i      ( clk_i                  ),
      .arst_n_i   ( arst_n_i               ),
      .push_i     ( pc_push[i]             ),
      .pc_i       ( commit_instr_i[i].pc   ),
      .pop_i      ( pc_pop[i]              ),
      .empty_o    ( pc_empty[i]            ),
      .pc_o       ( pc_head[i]             ),
      .overflow_o ( pc_overflow[i]         )
    );
  end

  assign pc_overflow_o = |pc_overflow;

  pc_merge_arbiter pc_merge_arbiter_inst (
    .clk_i      ( clk_i      ),
    .arst_n_i   ( arst_n_i   ),
    .empty_i    ( pc_empty   ),
    .pc_i       ( pc_head    ),
    .pop_o      ( pc_pop     ),
    .pc_valid_o ( pc_valid_o ),
    .pc_o       ( pc_o       )
  );

  // ------------------------------
  // performance counters
  // ------------------------------
  perf_counters perf_counters_inst (
    .clk_i          ( clk_i          ),
    .arst_n_i       ( arst_n_i       ),
    .debug_mode_i   ( debug_mode_i   ),
    .perf_req_i     ( perf_req_i     ),
    .perf_rdata_o   ( perf_rdata_o   ),
    .commit_instr_i ( commit_instr_i ),
    .commit_ack_i   ( commit_ack_i   ),
    .icache_miss_i  ( icache_miss_i  ),
    .dcache_miss_i  ( dcache_miss_i  ),
    .if_empty_i     ( if_empty_i     )
  );

endmodule

// ==== logic/pc_merge_arbiter.sv ====
// Round-robin merge of the per-port PC queues into one registered PC stream.
// One non-empty queue is popped per cycle, starting after the last grant.
`timescale 1ns/1ps

module pc_merge_arbiter (
  input  logic                                                               clk_i,
  input  logic                                                               arst_n_i,
  input  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0]                       empty_i,
  input  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0][commit_trace_pkg::VLEN-1:0] pc_i,
  output logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0]                       pop_o,
  output logic                                                               pc_valid_o,
  output logic [commit_trace_pkg::VLEN-1:0]                                  pc_o
);

  logic [$clog2(commit_trace_pkg::NR_COMMIT_PORTS)-1:0] last_q;
  logic [$clog2(commit_trace_pkg::NR_COMMIT_PORTS)-1:0] grant_idx;
  logic                                                 grant_valid;

  logic                              pc_valid_q;
  logic [commit_trace_pkg::VLEN-1:0] pc_q;

  // ------------------------------
  // grant selection
  // ------------------------------
  // scan from the port after the last grant, wrapping around
  always_comb begin
    int unsigned idx;
    grant_valid = 1'b0;
    grant_idx   = last_q;
    idx         = 0;
    for (int k = 1; k <= commit_trace_pkg::NR_COMMIT_PORTS; k++) begin
      idx = (int'(last_q) + k) % commit_trace_pkg::NR_COMMIT_PORTS;
      if (!grant_valid && !empty_i[idx]) begin
        grant_valid = 1'b1;
        grant_idx   = idx[$clog2(commit_trace_pkg::NR_COMMIT_PORTS)-1:0];
      end
    end
  end

  always_comb begin
    pop_o = '0;
    if (grant_valid) begin
      pop_o[grant_idx] = 1'b1;
    end
  end

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pc_valid_q <= 1'b0;
      last_q     <= '0;
    end else begin
      pc_valid_q <= grant_valid;
      if (grant_valid) begin
        last_q <= grant_idx;
      end
    end
  end

  // head of the granted queue, valid only with the strobe
  always_ff @(posedge clk_i) begin
    if (grant_valid) begin
      pc_q <= pc_i[grant_idx];
    end
  end

  assign pc_valid_o = pc_valid_q;
  assign pc_o       = pc_q;

endmodule

// ==== logic/pc_queue.sv ====
// Retired-PC FIFO for a single commit port. Pushes into a full queue are
// dropped and raise a sticky overflow flag that only reset clears.
`timescale 1ns/1ps

module pc_queue (
  input  logic                              clk_i,
  input  logic                              arst_n_i,
  input  logic                              push_i,
  input  logic [commit_trace_pkg::VLEN-1:0] pc_i,
  input  logic                              pop_i,
  output logic                              empty_o,
  output logic [commit_trace_pkg::VLEN-1:0] pc_o,
  output logic                              overflow_o
);

  logic [commit_trace_pkg::VLEN-1:0] mem_q [commit_trace_pkg::PC_QUEUE_DEPTH];

  logic [commit_trace_pkg::PC_QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [commit_trace_pkg::PC_QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [commit_trace_pkg::PC_QUEUE_PTR_W:0]   count_q;
  logic                                        overflow_q;

  logic full;
  logic push_ok;
  logic pop_ok;

  assign empty_o = (count_q == '0);
  assign full    = (count_q == (commit_trace_pkg::PC_QUEUE_PTR_W + 1)'(
                                 commit_trace_pkg::PC_QUEUE_DEPTH));

  // a full queue still takes a push when the head leaves in the same cycle
  assign pop_ok  = pop_i & ~empty_o;
  assign push_ok = push_i & (~full | pop_ok);

  // ------------------------------
  // pointers and occupancy
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      count_q    <= '0;
      overflow_q <= 1'b0;
    end else begin
      if (push_ok) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push_ok && !pop_ok) begin
        count_q <= count_q + 1'b1;
      end else if (pop_ok && !push_ok) begin
        count_q <= count_q - 1'b1;
      end
      if (push_i && !push_ok) begin
        overflow_q <= 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_ok) begin
      mem_q[wr_ptr_q] <= pc_i;
    end
  end

  assign pc_o       = mem_q[rd_ptr_q];
  assign overflow_o = overflow_q;

endmodule

// ==== logic/perf_counters.sv ====
// Performance counter register block with CSR-style access. Reads are
// combinational, writes land at the next edge and win over counting.
`timescale 1ns/1ps

module perf_counters (
  input  logic                                      clk_i,
  input  logic                                      arst_n_i,
  input  logic                                      debug_mode_i,
  input  commit_trace_pkg::perf_req_t               perf_req_i,
  output logic [commit_trace_pkg::XLEN-1:0]         perf_rdata_o,
  input  commit_trace_pkg::commit_entry_t [commit_trace_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0] commit_ack_i,
  input  logic                                      icache_miss_i,
  input  logic                                      dcache_miss_i,
  input  logic                                      if_empty_i
);

  logic [commit_trace_pkg::NR_PERF_CNT-1:0][commit_trace_pkg::XLEN-1:0] cnt_q;
  logic [commit_trace_pkg::NR_PERF_CNT-1:0][commit_trace_pkg::XLEN-1:0] cnt_d;

  // per-cycle increment of each counter, at most 2 with two commit ports
  logic [commit_trace_pkg::NR_PERF_CNT-1:0][1:0] inc;

  logic [1:0] n_retire;
  logic [1:0] n_exception;
  logic [1:0] n_interrupt;

  logic addr_hit;

  assign addr_hit = (perf_req_i.addr < commit_trace_pkg::PERF_ADDR_W'(
                                         commit_trace_pkg::NR_PERF_CNT));

  // ------------------------------
  // commit classification
  // ------------------------------
  always_comb begin
    n_retire    = '0;
    n_exception = '0;
    n_interrupt = '0;
    for (int i = 0; i < commit_trace_pkg::NR_COMMIT_PORTS; i++) begin
      if (commit_ack_i[i]) begin
        if (!commit_instr_i[i].ex_valid) begin
          n_retire = n_retire + 2'd1;
        end else if (commit_instr_i[i].cause.fields.is_interrupt) begin
          n_interrupt = n_interrupt + 2'd1;
        end else begin
          n_exception = n_exception + 2'd1;
        end
      end
    end
  end

  // ------------------------------
  // event map
  // ------------------------------
  always_comb begin
    inc = '0;
    inc[commit_trace_pkg::PERF_CYCLE]       = 2'd1;
    inc[commit_trace_pkg::PERF_INSTRET]     = n_retire;
    inc[commit_trace_pkg::PERF_EXCEPTION]   = n_exception;
    inc[commit_trace_pkg::PERF_INTERRUPT]   = n_interrupt;
    inc[commit_trace_pkg::PERF_ICACHE_MISS] = {1'b0, icache_miss_i};
    inc[commit_trace_pkg::PERF_DCACHE_MISS] = {1'b0, dcache_miss_i};
    inc[commit_trace_pkg::PERF_IF_EMPTY]    = {1'b0, if_empty_i};
  end

  // ------------------------------
  // next state
  // ------------------------------
  // counting freezes in debug mode, writes still go through
  always_comb begin
    cnt_d = cnt_q;
    if (!debug_mode_i) begin
      for (int i = 0; i < commit_trace_pkg::NR_PERF_CNT; i++) begin
        cnt_d[i] = cnt_q[i] + commit_trace_pkg::XLEN'(inc[i]);
      end
    end
    if (perf_req_i.we && addr_hit) begin
      cnt_d[perf_req_i.addr] = perf_req_i.wdata;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // unmapped addresses read zero
  always_comb begin
    perf_rdata_o = '0;
    if (addr_hit) begin
      perf_rdata_o = cnt_q[perf_req_i.addr];
    end
  end

endmodule

// ==== logic/trace_port_stage.sv ====
// Trace port register stage. Classifies each acknowledged commit as retired,
// exception or interrupt and presents it one cycle later on trace_o.
`timescale 1ns/1ps

module trace_port_stage (
  input  logic                                                          clk_i,
  input  logic                                                          arst_n_i,
  input  commit_trace_pkg::commit_entry_t [commit_trace_pkg::NR_COMMIT_PORTS-1:0] commit_instr_i,
  input  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0]                  commit_ack_i,
  output commit_trace_pkg::trace_entry_t  [commit_trace_pkg::NR_COMMIT_PORTS-1:0] trace_o
);

  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0] valid_q;
  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0] exception_q;
  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0] interrupt_q;

  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0][commit_trace_pkg::VLEN-1:0]   iaddr_q;
  logic [commit_trace_pkg::NR_COMMIT_PORTS-1:0][commit_trace_pkg::INSN_W-1:0] insn_q;
  commit_trace_pkg::cause_t [commit_trace_pkg::NR_COMMIT_PORTS-1:0]           cause_q;

  // ------------------------------
  // classification flags
  // ------------------------------
  // flags live for exactly one cycle after the ack
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_q     <= '0;
      exception_q <= '0;
      interrupt_q <= '0;
    end else begin
      for (int i = 0; i < commit_trace_pkg::NR_COMMIT_PORTS; i++) begin
        valid_q[i]     <= commit_ack_i[i] & ~commit_instr_i[i].ex_valid;
        exception_q[i] <= commit_ack_i[i] & commit_instr_i[i].ex_valid
                          & ~commit_instr_i[i].cause.fields.is_interrupt;
        interrupt_q[i] <= commit_ack_i[i] & commit_instr_i[i].ex_valid
                          & commit_instr_i[i].cause.fields.is_interrupt;
      end
    end
  end

  // ------------------------------
  // payload
  // ------------------------------
  // held between acks
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < commit_trace_pkg::NR_COMMIT_PORTS; i++) begin
      if (commit_ack_i[i]) begin
        iaddr_q[i] <= commit_instr_i[i].pc;
        insn_q[i]  <= commit_instr_i[i].insn;
        cause_q[i] <= commit_instr_i[i].cause;
      end
    end
  end

  for (genvar i = 0; i < commit_trace_pkg::NR_COMMIT_PORTS; i++) begin : gen_trace_out
    assign trace_o[i].valid     = valid_q[i];
    assign trace_o[i].exception = exception_q[i];
    assign trace_o[i].interrupt = interrupt_q[i];
    assign trace_o[i].iaddr     = iaddr_q[i];
    assign trace_o[i].insn      = insn_q[i];
    assign trace_o[i].cause     = cause_q[i];
  end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the commit trace unit testbench with Verilator.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_commit_trace_unit \
  -f all.f -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TB PASSED$" "$LOG"; then
  echo "simulation passed"
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// ==== verification/tb_commit_trace_unit.sv ====
// Random-stimulus testbench for the commit trace unit. Drives both commit ports,
// the event pulses and counter accesses, and checks every output against a model.
`timescale 1ns/1ps

module tb_commit_trace_unit;

  localparam int NP        = commit_trace_pkg::NR_COMMIT_PORTS;
  localparam int PERIOD    = 100;
  localparam int RESET_CYC = 8;
  localparam int RUN_CYC   = 3000;
  localparam int DRAIN_CYC = 64;
  localparam int DRIVE_DLY = 10;

  logic                                     clk;
  logic                                     arst_n;
  commit_trace_pkg::commit_entry_t [NP-1:0] commit_instr;
  logic [NP-1:0]                            commit_ack;
  logic                                     debug_mode;
  logic                                     icache_miss;
  logic                                     dcache_miss;
  logic                                     if_empty;
  commit_trace_pkg::perf_req_t              perf_req;
  commit_trace_pkg::trace_entry_t [NP-1:0]  trace;
  logic [commit_trace_pkg::XLEN-1:0]        perf_rdata;
  logic                                     pc_valid;
  logic [commit_trace_pkg::VLEN-1:0]        pc;
  logic                                     pc_overflow;

  integer seed;
  int     debug_left;

  // reference model state
  logic [commit_trace_pkg::XLEN-1:0] model_cnt [commit_trace_pkg::NR_PERF_CNT];
  logic [commit_trace_pkg::VLEN-1:0] pc_exp0 [$];
  logic [commit_trace_pkg::VLEN-1:0] pc_exp1 [$];
  commit_trace_pkg::trace_entry_t    exp_trace [NP];
  bit                                payload_seen [NP];

  commit_trace_unit commit_trace_unit_inst (
    .clk_i          ( clk          ),
    .arst_n_i       ( arst_n       ),
    .commit_instr_i ( commit_instr ),
    .commit_ack_i   ( commit_ack   ),
    .debug_mode_i   ( debug_mode   ),
    .icache_miss_i  ( icache_miss  ),
    .dcache_miss_i  ( dcache_miss  ),
    .if_empty_i     ( if_empty     ),
    .perf_req_i     ( perf_req     ),
    .trace_o        ( trace        ),
    .perf_rdata_o   ( perf_rdata   ),
    .pc_valid_o     ( pc_valid     ),
    .pc_o           ( pc           ),
    .pc_overflow_o  ( pc_overflow  )
  );

  initial clk = 1'b0;
  always #(PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] rand32();
    rand32 = $random(seed);
  endfunction

  task automatic check_cond(input bit ok, input string what);
    assert (ok) else begin
      $display("** Error at %0t ns: %s", $time, what);
      $display("TB FAILED");
      $fatal(1, "stopping at first error");
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  // low commit rate keeps the queues far from full
  task automatic drive_inputs(input bit allow_commits);
    logic [31:0] r;
    logic [31:0] hi;
    logic [31:0] lo;
    for (int i = 0; i < NP; i++) begin
      r  = rand32();
      hi = rand32();
      lo = rand32();
      commit_instr[i].pc         = {hi[7:0], lo};
      commit_instr[i].insn       = rand32();
      commit_instr[i].ex_valid   = (r[4:3] == 2'd0);
      commit_instr[i].cause.word = {rand32(), rand32()};
      commit_instr[i].cause.fields.is_interrupt = r[5];
      commit_ack[i] = allow_commits && (r[2:0] == 3'd0);
    end
    r = rand32();
    icache_miss = (r[2:0] == 3'd0);
    dcache_miss = (r[5:3] == 3'd0);
    if_empty    = (r[8:6] == 3'd0);
    // debug bursts of 5 to 20 cycles
    if (debug_left > 0) begin
      debug_mode = 1'b1;
      debug_left = debug_left - 1;
    end else if (r[14:9] == 6'd0) begin
      debug_mode = 1'b1;
      debug_left = 4 + int'(r[18:15]);
    end else begin
      debug_mode = 1'b0;
    end
    hi = rand32();
    lo = rand32();
    perf_req.we    = (r[22:19] == 4'd0);
    perf_req.addr  = (r[24:23] != 2'd0) ? 5'(r[31:25] % 7) : r[29:25];
    perf_req.wdata = {hi, lo};
  endtask

  // ------------------------------
  // model and checks
  // ------------------------------
  task automatic check_read();
    logic [commit_trace_pkg::XLEN-1:0] expected;
    expected = '0;
    if (int'(perf_req.addr) < commit_trace_pkg::NR_PERF_CNT) begin
      expected = model_cnt[int'(perf_req.addr)];
    end
    check_cond(perf_rdata == expected,
               $sformatf("counter %0d reads %h, expected %h",
                         perf_req.addr, perf_rdata, expected));
  endtask

  // next state from the inputs driven in this cycle
  task automatic update_model();
    int n_ret;
    int n_exc;
    int n_int;
    n_ret = 0;
    n_exc = 0;
    n_int = 0;
    for (int i = 0; i < NP; i++) begin
      exp_trace[i].valid     = 1'b0;
      exp_trace[i].exception = 1'b0;
      exp_trace[i].interrupt = 1'b0;
      if (commit_ack[i]) begin
        exp_trace[i].iaddr = commit_instr[i].pc;
        exp_trace[i].insn  = commit_instr[i].insn;
        exp_trace[i].cause = commit_instr[i].cause;
        payload_seen[i]    = 1'b1;
        if (!commit_instr[i].ex_valid) begin
          exp_trace[i].valid = 1'b1;
          n_ret = n_ret + 1;
          if (i == 0) pc_exp0.push_back(commit_instr[i].pc);
          else pc_exp1.push_back(commit_instr[i].pc);
        end else if (commit_instr[i].cause.word[commit_trace_pkg::XLEN-1]) begin
          exp_trace[i].interrupt = 1'b1;
          n_int = n_int + 1;
        end else begin
          exp_trace[i].exception = 1'b1;
          n_exc = n_exc + 1;
        end
      end
    end
    if (!debug_mode) begin
      model_cnt[0] = model_cnt[0] + 64'd1;
      model_cnt[1] = model_cnt[1] + 64'(n_ret);
      model_cnt[2] = model_cnt[2] + 64'(n_exc);
      model_cnt[3] = model_cnt[3] + 64'(n_int);
      model_cnt[4] = model_cnt[4] + 64'(icache_miss);
      model_cnt[5] = model_cnt[5] + 64'(dcache_miss);
      model_cnt[6] = model_cnt[6] + 64'(if_empty);
    end
    // write lands last so it wins over the count
    if (perf_req.we && int'(perf_req.addr) < commit_trace_pkg::NR_PERF_CNT) begin
      model_cnt[int'(perf_req.addr)] = perf_req.wdata;
    end
  endtask

  task automatic check_outputs();
    for (int i = 0; i < NP; i++) begin
      check_cond({trace[i].valid, trace[i].exception, trace[i].interrupt} ==
                 {exp_trace[i].valid, exp_trace[i].exception, exp_trace[i].interrupt},
                 $sformatf("port %0d trace flags %b%b%b, expected %b%b%b", i,
                           trace[i].valid, trace[i].exception, trace[i].interrupt,
                           exp_trace[i].valid, exp_trace[i].exception,
                           exp_trace[i].interrupt));
      if (payload_seen[i]) begin
        check_cond(trace[i].iaddr == exp_trace[i].iaddr &&
                   trace[i].insn == exp_trace[i].insn &&
                   trace[i].cause.word == exp_trace[i].cause.word,
                   $sformatf("port %0d trace payload pc %h insn %h, expected pc %h insn %h",
                             i, trace[i].iaddr, trace[i].insn,
                             exp_trace[i].iaddr, exp_trace[i].insn));
      end
    end
    check_cond(pc_overflow == 1'b0, "pc overflow flag went high");
    if (pc_valid) begin
      if (pc_exp0.size() > 0 && pc_exp0[0] == pc) begin
        void'(pc_exp0.pop_front());
      end else if (pc_exp1.size() > 0 && pc_exp1[0] == pc) begin
        void'(pc_exp1.pop_front());
      end else begin
        check_cond(1'b0, $sformatf("merged pc %h matches no expected queue head", pc));
      end
    end
  endtask

  task automatic run_cycle(input bit allow_commits);
    drive_inputs(allow_commits);
    #1;
    check_read();
    update_model();
    @(posedge clk);
    #(DRIVE_DLY);
    check_outputs();
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------
  initial begin
    seed         = 55;
    debug_left   = 0;
    arst_n       = 1'b0;
    commit_instr = '0;
    commit_ack   = '0;
    debug_mode   = 1'b0;
    icache_miss  = 1'b0;
    dcache_miss  = 1'b0;
    if_empty     = 1'b0;
    perf_req     = '0;
    for (int i = 0; i < commit_trace_pkg::NR_PERF_CNT; i++) begin
      model_cnt[i] = '0;
    end
    for (int i = 0; i < NP; i++) begin
      exp_trace[i]    = '0;
      payload_seen[i] = 1'b0;
    end

    repeat (RESET_CYC) @(posedge clk);
    #(DRIVE_DLY);
    for (int i = 0; i < NP; i++) begin
      check_cond(!trace[i].valid && !trace[i].exception && !trace[i].interrupt,
                 $sformatf("port %0d trace flags set during reset", i));
    end
    check_cond(!pc_valid && !pc_overflow, "pc strobe or overflow set during reset");
    arst_n = 1'b1;

    // every address, mapped or not, reads zero before the first edge
    for (int a = 0; a < 8; a++) begin
      perf_req.addr = 5'(a);
      #1;
      check_cond(perf_rdata == '0,
                 $sformatf("counter %0d reads %h after reset", a, perf_rdata));
    end

    for (int c = 0; c < RUN_CYC + DRAIN_CYC; c++) begin
      run_cycle(c < RUN_CYC);
    end
    check_cond(pc_exp0.size() == 0 && pc_exp1.size() == 0,
               $sformatf("expected PCs left after drain, port0 %0d port1 %0d",
                         pc_exp0.size(), pc_exp1.size()));
    $display("TB PASSED");
    $finish;
  end

  // watchdog
  initial begin
    #(2 * (RESET_CYC + RUN_CYC + DRAIN_CYC) * PERIOD);
    $display("** Error at %0t ns: the run did not finish in time", $time);
    $display("TB FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule
